// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mipsPipeline_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
cpuPkg.sv
registerFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryWriteback.sv
mipsPipeline.sv
mipsPipeline_assertions.sv
mipsPipeline_tb.sv

// ==== cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] dataWord;     // data, address or instruction
    typedef logic [4:0]  regIndex;
    typedef logic [5:0]  opcodeField;
    typedef logic [5:0]  functField;
    typedef logic [4:0]  shiftAmount;
    typedef logic [3:0]  aluOperation;

    // primary opcodes
    localparam opcodeField opRType = 6'b000000;
    localparam opcodeField opJ     = 6'b000010;
    localparam opcodeField opBeq   = 6'b000100;
    localparam opcodeField opBne   = 6'b000101;
    localparam opcodeField opAddi  = 6'b001000;
    localparam opcodeField opAddiu = 6'b001001;
    localparam opcodeField opAndi  = 6'b001100;
    localparam opcodeField opOri   = 6'b001101;
    localparam opcodeField opXori  = 6'b001110;
    localparam opcodeField opLw    = 6'b100011;
    localparam opcodeField opSw    = 6'b101011;

    // function codes of register-register instructions
    localparam functField fnSll  = 6'b000000;
    localparam functField fnSrl  = 6'b000010;
    localparam functField fnSra  = 6'b000011;
    localparam functField fnAdd  = 6'b100000;
    localparam functField fnAddu = 6'b100001;
    localparam functField fnSub  = 6'b100010;
    localparam functField fnSubu = 6'b100011;
    localparam functField fnAnd  = 6'b100100;
    localparam functField fnOr   = 6'b100101;
    localparam functField fnXor  = 6'b100110;
    localparam functField fnNor  = 6'b100111;
    localparam functField fnSlt  = 6'b101010;

    localparam aluOperation aluAdd   = 4'd0;
    localparam aluOperation aluSub   = 4'd1;
    localparam aluOperation aluAnd   = 4'd2;
    localparam aluOperation aluOr    = 4'd3;
    localparam aluOperation aluXor   = 4'd4;
    localparam aluOperation aluNor   = 4'd5;
    localparam aluOperation aluSlt   = 4'd6;   // signed compare
    localparam aluOperation aluSll   = 4'd7;
    localparam aluOperation aluSrl   = 4'd8;
    localparam aluOperation aluSra   = 4'd9;
    localparam aluOperation aluPass  = 4'd10;  // operand B straight through
    localparam aluOperation aluEqual = 4'd11;  // 1 when operands match

    localparam dataWord nopWord = 32'h0000_0000;

endpackage

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic                CLOCK,
    input  logic                RESET,
    input  logic                flush,
    input  cpuPkg::dataWord     instrDecode,
    input  cpuPkg::dataWord     pcPlus4Decode,
    input  logic                writeEnable,
    input  cpuPkg::regIndex     writeIndex,
    input  cpuPkg::dataWord     writeData,
    output logic                regWriteExecute,
    output logic                memToRegExecute,
    output logic                memWriteExecute,
    output logic                branchExecute,
    output logic                branchOnEqualExecute,
    output logic                jumpExecute,
    output logic                aluSrcExecute,
    output logic                regDstExecute,
    output cpuPkg::aluOperation aluOpExecute,
    output cpuPkg::shiftAmount  shamtExecute,
    output cpuPkg::dataWord     srcAExecute,
    output cpuPkg::dataWord     storeDataExecute,
    output cpuPkg::dataWord     immediateExecute,
    output cpuPkg::dataWord     jumpTargetExecute,
    output cpuPkg::dataWord     pcPlus4Execute,
    output cpuPkg::regIndex     rtExecute,
    output cpuPkg::regIndex     rdExecute
);

    cpuPkg::opcodeField  opcode;
    cpuPkg::functField   funct;
    cpuPkg::regIndex     rs;
    cpuPkg::regIndex     rt;
    cpuPkg::regIndex     rd;
    cpuPkg::regIndex     destination;
    cpuPkg::dataWord     readDataA;
    cpuPkg::dataWord     readDataB;
    cpuPkg::dataWord     immediate;
    cpuPkg::aluOperation aluOp;
    logic regWrite, memToRegSel, memWrite, branch, branchOnEqual;
    logic jump, aluSrc, regDst, zeroExtend;

    assign opcode = instrDecode[31:26];
    assign rs = instrDecode[25:21];
    assign rt = instrDecode[20:16];
    assign rd = instrDecode[15:11];
    assign funct = instrDecode[5:0];
    assign destination = regDst ? rd : rt;
    assign immediate = zeroExtend ? {16'b0, instrDecode[15:0]}
                                  : {{16{instrDecode[15]}}, instrDecode[15:0]};

    always_comb
    begin
        regWrite = 1'b0;
        memToRegSel = 1'b0;
        memWrite = 1'b0;
        branch = 1'b0;
        branchOnEqual = 1'b0;
        jump = 1'b0;
        aluSrc = 1'b0;
        regDst = 1'b0;
        zeroExtend = 1'b0;
        aluOp = cpuPkg::aluPass;
        case (opcode)
            cpuPkg::opRType:
            begin
                regWrite = 1'b1;
                regDst = 1'b1;
                case (funct)
                    cpuPkg::fnAdd, cpuPkg::fnAddu: aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSub, cpuPkg::fnSubu: aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd: aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:  aluOp = cpuPkg::aluOr;
                    cpuPkg::fnXor: aluOp = cpuPkg::aluXor;
                    cpuPkg::fnNor: aluOp = cpuPkg::aluNor;
                    cpuPkg::fnSlt: aluOp = cpuPkg::aluSlt;
                    cpuPkg::fnSll: aluOp = cpuPkg::aluSll;
                    cpuPkg::fnSrl: aluOp = cpuPkg::aluSrl;
                    cpuPkg::fnSra: aluOp = cpuPkg::aluSra;
                    default:       regWrite = 1'b0;  // unknown funct is a no-op
                endcase
            end
            cpuPkg::opAddi, cpuPkg::opAddiu, cpuPkg::opLw:
            begin
                regWrite = 1'b1;
                aluSrc = 1'b1;
                memToRegSel = (opcode == cpuPkg::opLw);
                aluOp = cpuPkg::aluAdd;
            end
            cpuPkg::opAndi, cpuPkg::opOri, cpuPkg::opXori:
            begin
                regWrite = 1'b1;
                aluSrc = 1'b1;
                zeroExtend = 1'b1;
                aluOp = (opcode == cpuPkg::opAndi) ? cpuPkg::aluAnd :
                        (opcode == cpuPkg::opOri)  ? cpuPkg::aluOr : cpuPkg::aluXor;
            end
            cpuPkg::opSw:
            begin
                memWrite = 1'b1;
                aluSrc = 1'b1;
                aluOp = cpuPkg::aluAdd;
            end
            cpuPkg::opBeq, cpuPkg::opBne:
            begin
                branch = 1'b1;
                branchOnEqual = (opcode == cpuPkg::opBeq);
                aluOp = cpuPkg::aluEqual;
            end
            cpuPkg::opJ: jump = 1'b1;
            default: ;                       // unknown opcode writes nothing
        endcase
    end

    registerFile i_registerFile (
        .CLOCK(CLOCK),
        .RESET(RESET),
        .readIndexA(rs),
        .readIndexB(rt),
        .writeEnable(writeEnable),
        .writeIndex(writeIndex),
        .writeData(writeData),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    always_ff @(posedge CLOCK)
    begin
        if (RESET || flush)
        begin
            regWriteExecute <= 1'b0;
            memToRegExecute <= 1'b0;
            memWriteExecute <= 1'b0;
            branchExecute <= 1'b0;
            branchOnEqualExecute <= 1'b0;
            jumpExecute <= 1'b0;
            aluSrcExecute <= 1'b0;
            regDstExecute <= 1'b0;
        end
        else
        begin
            regWriteExecute <= regWrite && (destination != '0);  // r0 never written
            memToRegExecute <= memToRegSel;
            memWriteExecute <= memWrite;
            branchExecute <= branch;
            branchOnEqualExecute <= branchOnEqual;
            jumpExecute <= jump;
            aluSrcExecute <= aluSrc;
            regDstExecute <= regDst;
        end
        aluOpExecute <= aluOp;
        shamtExecute <= instrDecode[10:6];
        srcAExecute <= readDataA;
        storeDataExecute <= readDataB;
        immediateExecute <= immediate;
        jumpTargetExecute <= {pcPlus4Decode[31:28], instrDecode[25:0], 2'b00};
        pcPlus4Execute <= pcPlus4Decode;
        rtExecute <= rt;
        rdExecute <= rd;
    end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input  logic                CLOCK,
    input  logic                RESET,
    input  logic                flush,
    input  logic                regWriteExecute,
    input  logic                memToRegExecute,
    input  logic                memWriteExecute,
    input  logic                branchExecute,
    input  logic                branchOnEqualExecute,
    input  logic                jumpExecute,
    input  logic                aluSrcExecute,
    input  logic                regDstExecute,
    input  cpuPkg::aluOperation aluOpExecute,
    input  cpuPkg::shiftAmount  shamtExecute,
    input  cpuPkg::dataWord     srcAExecute,
    input  cpuPkg::dataWord     storeDataExecute,
    input  cpuPkg::dataWord     immediateExecute,
    input  cpuPkg::dataWord     jumpTargetExecute,
    input  cpuPkg::dataWord     pcPlus4Execute,
    input  cpuPkg::regIndex     rtExecute,
    input  cpuPkg::regIndex     rdExecute,
    output logic                regWriteMemory,
    output logic                memToRegMemory,
    output logic                memWriteMemory,
    output logic                takeBranchMemory,
    output cpuPkg::dataWord     aluResultMemory,
    output cpuPkg::dataWord     storeDataMemory,
    output cpuPkg::regIndex     writeIndexMemory,
    output cpuPkg::dataWord     branchTargetMemory
);

    cpuPkg::dataWord srcB;
    cpuPkg::dataWord aluResult;
    cpuPkg::dataWord branchTarget;
    cpuPkg::regIndex writeIndex;
    logic            takeBranch;

    assign srcB = aluSrcExecute ? immediateExecute : storeDataExecute;
    assign writeIndex = regDstExecute ? rdExecute : rtExecute;

    always_comb
    begin
        case (aluOpExecute)
            cpuPkg::aluAdd:   aluResult = srcAExecute + srcB;
            cpuPkg::aluSub:   aluResult = srcAExecute - srcB;
            cpuPkg::aluAnd:   aluResult = srcAExecute & srcB;
            cpuPkg::aluOr:    aluResult = srcAExecute | srcB;
            cpuPkg::aluXor:   aluResult = srcAExecute ^ srcB;
            cpuPkg::aluNor:   aluResult = ~(srcAExecute | srcB);
            cpuPkg::aluSlt:   aluResult = {31'b0, $signed(srcAExecute) < $signed(srcB)};
            cpuPkg::aluSll:   aluResult = srcB << shamtExecute;
            cpuPkg::aluSrl:   aluResult = srcB >> shamtExecute;
            cpuPkg::aluSra:   aluResult = $signed(srcB) >>> shamtExecute;
            cpuPkg::aluEqual: aluResult = {31'b0, srcAExecute == srcB};
            default:          aluResult = srcB;   // pass
        endcase
    end

    // beq wants equal, bne wants not equal
    assign takeBranch = jumpExecute ||
                        (branchExecute && (aluResult[0] == branchOnEqualExecute));
    assign branchTarget = jumpExecute ? jumpTargetExecute
                                      : pcPlus4Execute + {immediateExecute[29:0], 2'b00};

    always_ff @(posedge CLOCK)
    begin
        if (RESET || flush)
        begin
            regWriteMemory <= 1'b0;
            memToRegMemory <= 1'b0;
            memWriteMemory <= 1'b0;
            takeBranchMemory <= 1'b0;
        end
        else
        begin
            regWriteMemory <= regWriteExecute;
            memToRegMemory <= memToRegExecute;
            memWriteMemory <= memWriteExecute;
            takeBranchMemory <= takeBranch;
        end
        aluResultMemory <= aluResult;
        storeDataMemory <= storeDataExecute;
        writeIndexMemory <= writeIndex;
        branchTargetMemory <= branchTarget;
    end

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage #(
    parameter cpuPkg::dataWord resetAddress = 32'h0000_0000
) (
    input  logic            CLOCK,
    input  logic            RESET,
    input  logic            redirect,
    input  cpuPkg::dataWord redirectTarget,
    input  cpuPkg::dataWord instrData,
    output cpuPkg::dataWord instrAddress,
    output cpuPkg::dataWord instrDecode,
    output cpuPkg::dataWord pcPlus4Decode
);

    cpuPkg::dataWord programCounter;
    cpuPkg::dataWord pcPlus4;

    assign pcPlus4 = programCounter + 32'd4;
    assign instrAddress = programCounter;

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
            programCounter <= resetAddress;
        else if (redirect)
            programCounter <= redirectTarget;   // taken branch or jump
        else
            programCounter <= pcPlus4;
    end

    always_ff @(posedge CLOCK)
    begin
        if (RESET || redirect)
            instrDecode <= cpuPkg::nopWord;     // squash the word in flight
        else
            instrDecode <= instrData;
        pcPlus4Decode <= pcPlus4;
    end

endmodule

// ==== memoryWriteback.sv ====
`timescale 1ns/1ps

module memoryWriteback (
    input  logic            CLOCK,
    input  logic            RESET,
    input  logic            regWriteMemory,
    input  logic            memToRegMemory,
    input  logic            memWriteMemory,
    input  logic            takeBranchMemory,
    input  cpuPkg::dataWord aluResultMemory,
    input  cpuPkg::dataWord storeDataMemory,
    input  cpuPkg::regIndex writeIndexMemory,
    input  cpuPkg::dataWord branchTargetMemory,
    input  cpuPkg::dataWord dataReadData,
    output logic            redirect,
    output cpuPkg::dataWord redirectTarget,
    output cpuPkg::dataWord dataAddress,
    output cpuPkg::dataWord dataWriteData,
    output logic            dataWrite,
    output logic            regWriteEnable,
    output cpuPkg::regIndex regWriteIndex,
    output cpuPkg::dataWord regWriteData
);

    logic            memToRegWriteback;
    cpuPkg::dataWord aluResultWriteback;
    cpuPkg::dataWord readDataWriteback;

    assign redirect = takeBranchMemory;   // also flushes the three younger stages
    assign redirectTarget = branchTargetMemory;
    assign dataAddress = aluResultMemory;
    assign dataWriteData = storeDataMemory;
    assign dataWrite = memWriteMemory;

    // never flushed so the instruction ahead of a branch still retires
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            regWriteEnable <= 1'b0;
            memToRegWriteback <= 1'b0;
        end
        else
        begin
            regWriteEnable <= regWriteMemory;
            memToRegWriteback <= memToRegMemory;
        end
        regWriteIndex <= writeIndexMemory;
        aluResultWriteback <= aluResultMemory;
        readDataWriteback <= dataReadData;
    end

    assign regWriteData = memToRegWriteback ? readDataWriteback : aluResultWriteback;

endmodule

// ==== mipsPipeline.sv ====
`timescale 1ns/1ps

module mipsPipeline #(
    parameter cpuPkg::dataWord resetAddress = 32'h0000_0000
) (
    input  logic            CLOCK,
    input  logic            RESET,
    input  cpuPkg::dataWord instrData,
    input  cpuPkg::dataWord dataReadData,
    output cpuPkg::dataWord instrAddress,
    output cpuPkg::dataWord dataAddress,
    output cpuPkg::dataWord dataWriteData,
    output logic            dataWrite,
    output logic            regWriteEnable,
    output cpuPkg::regIndex regWriteIndex,
    output cpuPkg::dataWord regWriteData
);

    logic               redirect;
    cpuPkg::dataWord    redirectTarget;
    cpuPkg::dataWord    instrDecode;
    cpuPkg::dataWord    pcPlus4Decode;

    // decode to execute
    logic               regWriteExecute;
    logic               memToRegExecute;
    logic               memWriteExecute;
    logic               branchExecute;
    logic               branchOnEqualExecute;
    logic               jumpExecute;
    logic               aluSrcExecute;
    logic               regDstExecute;
    cpuPkg::aluOperation aluOpExecute;
    cpuPkg::shiftAmount shamtExecute;
    cpuPkg::dataWord    srcAExecute;
    cpuPkg::dataWord    storeDataExecute;
    cpuPkg::dataWord    immediateExecute;
    cpuPkg::dataWord    jumpTargetExecute;
    cpuPkg::dataWord    pcPlus4Execute;
    cpuPkg::regIndex    rtExecute;
    cpuPkg::regIndex    rdExecute;

    // execute to memory
    logic               regWriteMemory;
    logic               memToRegMemory;
    logic               memWriteMemory;
    logic               takeBranchMemory;
    cpuPkg::dataWord    aluResultMemory;
    cpuPkg::dataWord    storeDataMemory;
    cpuPkg::regIndex    writeIndexMemory;
    cpuPkg::dataWord    branchTargetMemory;

    fetchStage #(
        .resetAddress(resetAddress)
    ) i_fetchStage (
        .*
    );

    decodeStage i_decodeStage (
        .flush(redirect),
        .writeEnable(regWriteEnable),   // write-back result into the register file
        .writeIndex(regWriteIndex),
        .writeData(regWriteData),
        .*
    );

    executeStage i_executeStage (
        .flush(redirect),
        .*
    );

    memoryWriteback i_memoryWriteback (
        .*
    );

endmodule

// ==== mipsPipeline_assertions.sv ====
`timescale 1ns/1ps

module mipsPipeline_assertions (
    input  logic            CLOCK,
    input  logic            RESET,
    input  cpuPkg::dataWord instrAddress,
    input  logic            dataWrite,
    input  logic            regWriteEnable,
    input  cpuPkg::regIndex regWriteIndex
);

    // nothing retires in the first cycle out of reset
    quietAfterReset: assert property (@(posedge CLOCK)
        RESET |=> (!dataWrite && !regWriteEnable))
        else $error("write strobe high in the cycle after reset");

    wordAligned: assert property (@(posedge CLOCK) disable iff (RESET)
        instrAddress[1:0] == 2'b00)
        else $error("instruction address %h is not word aligned", instrAddress);

    noWriteToZero: assert property (@(posedge CLOCK)
        regWriteEnable |-> (regWriteIndex != '0))
        else $error("write-back targets register 0");   // decode must drop these

endmodule

bind mipsPipeline mipsPipeline_assertions i_mipsPipeline_assertions (.*);

// ==== mipsPipeline_tb.sv ====
`timescale 1ns/1ps

module mipsPipeline_tb;

    localparam cpuPkg::dataWord startAddress = 32'h0000_0100;
    localparam int firstWriteCycle = 4;     // pipeline fill after reset
    localparam int drainCycles = 4;

    logic            CLOCK;
    logic            RESET;
    cpuPkg::dataWord instrData;
    cpuPkg::dataWord dataReadData;
    cpuPkg::dataWord instrAddress;
    cpuPkg::dataWord dataAddress;
    cpuPkg::dataWord dataWriteData;
    logic            dataWrite;
    logic            regWriteEnable;
    cpuPkg::regIndex regWriteIndex;
    cpuPkg::dataWord regWriteData;

    cpuPkg::dataWord instrMemory [256];
    cpuPkg::dataWord dataMemory [256];

    cpuPkg::dataWord programWords [$];
    cpuPkg::regIndex expectedIndex [$];
    cpuPkg::dataWord expectedValue [$];
    cpuPkg::dataWord expectedStoreAddress [$];
    cpuPkg::dataWord expectedStoreData [$];

    int mismatchCount = 0;
    int failureCount = 0;
    int writesSeen = 0;
    int storesSeen = 0;
    int cyclesAfterReset = 0;
    int cycleLimit;

    mipsPipeline #(
        .resetAddress(startAddress)
    ) i_mipsPipeline (.*);

    // memories answer in the same cycle
    assign instrData = instrMemory[instrAddress[9:2]];
    assign dataReadData = dataMemory[dataAddress[9:2]];

    initial
    begin
        CLOCK = 1'b0;
        forever #50 CLOCK = ~CLOCK;
    end

    function automatic cpuPkg::dataWord encodeR(input cpuPkg::functField funct,
            input cpuPkg::regIndex rs, input cpuPkg::regIndex rt,
            input cpuPkg::regIndex rd, input cpuPkg::shiftAmount shamt);
        return {cpuPkg::opRType, rs, rt, rd, shamt, funct};
    endfunction

    function automatic cpuPkg::dataWord encodeI(input cpuPkg::opcodeField opcode,
            input cpuPkg::regIndex rs, input cpuPkg::regIndex rt, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic cpuPkg::dataWord encodeJ(input logic [25:0] target);
        return {cpuPkg::opJ, target};
    endfunction

    task automatic addWriting(input cpuPkg::dataWord word, input cpuPkg::regIndex index,
            input cpuPkg::dataWord value);
        programWords.push_back(word);
        expectedIndex.push_back(index);
        expectedValue.push_back(value);
    endtask

    // shadow of a taken branch that must never write
    task automatic addSquashed(input int count);
        for (int i = 0; i < count; i++)
        begin
            programWords.push_back(encodeI(cpuPkg::opAddi, 5'd0, 5'd30, 16'h0bad));
        end
    endtask

    task automatic buildProgram;
        int jumpTarget;
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd1, 16'h0123), 5'd1, 32'h0000_0123);
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd2, 16'hff10), 5'd2, 32'hffff_ff10);
        addWriting(encodeI(cpuPkg::opAddiu, 5'd0, 5'd3, 16'h7ff0), 5'd3, 32'h0000_7ff0);
        addWriting(encodeI(cpuPkg::opOri, 5'd0, 5'd4, 16'h8001), 5'd4, 32'h0000_8001);
        addWriting(encodeI(cpuPkg::opAddiu, 5'd0, 5'd5, 16'hffff), 5'd5, 32'hffff_ffff);
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd22, 16'h0040), 5'd22, 32'h0000_0040);
        addWriting(encodeR(cpuPkg::fnAdd, 5'd1, 5'd2, 5'd6, 5'd0), 5'd6, 32'h0000_0033);
        addWriting(encodeR(cpuPkg::fnSub, 5'd1, 5'd2, 5'd7, 5'd0), 5'd7, 32'h0000_0213);
        addWriting(encodeR(cpuPkg::fnAnd, 5'd2, 5'd4, 5'd8, 5'd0), 5'd8, 32'h0000_8000);
        addWriting(encodeR(cpuPkg::fnOr, 5'd1, 5'd4, 5'd9, 5'd0), 5'd9, 32'h0000_8123);
        addWriting(encodeR(cpuPkg::fnXor, 5'd2, 5'd5, 5'd10, 5'd0), 5'd10, 32'h0000_00ef);
        addWriting(encodeR(cpuPkg::fnNor, 5'd1, 5'd3, 5'd11, 5'd0), 5'd11, 32'hffff_800c);
        addWriting(encodeR(cpuPkg::fnSlt, 5'd2, 5'd1, 5'd12, 5'd0), 5'd12, 32'h0000_0001);
        addWriting(encodeR(cpuPkg::fnSlt, 5'd1, 5'd2, 5'd13, 5'd0), 5'd13, 32'h0000_0000);
        addWriting(encodeR(cpuPkg::fnAddu, 5'd5, 5'd1, 5'd14, 5'd0), 5'd14, 32'h0000_0122);
        addWriting(encodeR(cpuPkg::fnSubu, 5'd1, 5'd5, 5'd15, 5'd0), 5'd15, 32'h0000_0124);
        addWriting(encodeR(cpuPkg::fnSll, 5'd0, 5'd1, 5'd16, 5'd4), 5'd16, 32'h0000_1230);
        addWriting(encodeR(cpuPkg::fnSrl, 5'd0, 5'd2, 5'd17, 5'd8), 5'd17, 32'h00ff_ffff);
        addWriting(encodeR(cpuPkg::fnSra, 5'd0, 5'd2, 5'd18, 5'd4), 5'd18, 32'hffff_fff1);
        addWriting(encodeI(cpuPkg::opAndi, 5'd2, 5'd19, 16'hf0f0), 5'd19, 32'h0000_f010);
        addWriting(encodeI(cpuPkg::opXori, 5'd5, 5'd20, 16'h8000), 5'd20, 32'hffff_7fff);
        addWriting(encodeI(cpuPkg::opAddi, 5'd1, 5'd21, 16'hfffc), 5'd21, 32'h0000_011f);
        programWords.push_back(encodeI(cpuPkg::opAddi, 5'd1, 5'd0, 16'h0055));  // r0 target
        programWords.push_back(encodeI(cpuPkg::opSw, 5'd22, 5'd11, 16'h0008));
        expectedStoreAddress.push_back(32'h0000_0048);
        expectedStoreData.push_back(32'hffff_800c);
        programWords.push_back(encodeI(cpuPkg::opSw, 5'd22, 5'd2, 16'hfffc));
        expectedStoreAddress.push_back(32'h0000_003c);
        expectedStoreData.push_back(32'hffff_ff10);
        addWriting(encodeI(cpuPkg::opXori, 5'd1, 5'd23, 16'h00ff), 5'd23, 32'h0000_01dc);
        addWriting(encodeR(cpuPkg::fnAdd, 5'd0, 5'd1, 5'd24, 5'd0), 5'd24, 32'h0000_0123);
        addWriting(encodeI(cpuPkg::opLw, 5'd22, 5'd25, 16'h0008), 5'd25, 32'hffff_800c);
        addWriting(encodeI(cpuPkg::opLw, 5'd22, 5'd26, 16'hfffc), 5'd26, 32'hffff_ff10);
        addWriting(encodeI(cpuPkg::opAndi, 5'd5, 5'd27, 16'h1234), 5'd27, 32'h0000_1234);
        programWords.push_back(encodeI(cpuPkg::opBeq, 5'd1, 5'd24, 16'h0004));  // taken
        addSquashed(4);
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd28, 16'h0011), 5'd28, 32'h0000_0011);
        programWords.push_back(encodeI(cpuPkg::opBeq, 5'd1, 5'd2, 16'h0004));   // falls through
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd28, 16'h0021), 5'd28, 32'h0000_0021);
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd28, 16'h0022), 5'd28, 32'h0000_0022);
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd28, 16'h0023), 5'd28, 32'h0000_0023);
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd28, 16'h0024), 5'd28, 32'h0000_0024);
        programWords.push_back(encodeI(cpuPkg::opBne, 5'd1, 5'd2, 16'h0004));   // taken
        addSquashed(4);
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd29, 16'h0031), 5'd29, 32'h0000_0031);
        jumpTarget = startAddress[27:2] + programWords.size() + 5;  // word index past the shadow
        programWords.push_back(encodeJ(jumpTarget[25:0]));
        addSquashed(4);
        addWriting(encodeI(cpuPkg::opAddi, 5'd0, 5'd29, 16'h0041), 5'd29, 32'h0000_0041);
    endtask

    // data memory holds a byte-address pattern until stored over
    always @(posedge CLOCK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 256; i++)
            begin
                dataMemory[i] <= 32'hd000_0000 | (i << 2);
            end
        end
        else if (dataWrite)
        begin
            dataMemory[dataAddress[9:2]] <= dataWriteData;
        end
    end

    always @(posedge CLOCK)
    begin
        if (!RESET)
            cyclesAfterReset <= cyclesAfterReset + 1;
    end

    always @(negedge CLOCK)
    begin
        if (regWriteEnable)
        begin
            if (writesSeen >= expectedIndex.size())
            begin
                $display("** Error at %0t ns: extra write of %h to r%0d",
                         $time, regWriteData, regWriteIndex);
                mismatchCount++;
            end
            else if (regWriteIndex != expectedIndex[writesSeen] ||
                     regWriteData != expectedValue[writesSeen])
            begin
                $display("** Error at %0t ns: write %0d is r%0d = %h, expected r%0d = %h",
                         $time, writesSeen, regWriteIndex, regWriteData,
                         expectedIndex[writesSeen], expectedValue[writesSeen]);
                mismatchCount++;
            end
            if (writesSeen == 0 && cyclesAfterReset != firstWriteCycle)
            begin
                $display("** Error at %0t ns: first write after %0d cycles, expected %0d",
                         $time, cyclesAfterReset, firstWriteCycle);
                mismatchCount++;
            end
            writesSeen++;
        end
        if (dataWrite)
        begin
            if (storesSeen >= expectedStoreAddress.size())
            begin
                $display("** Error at %0t ns: extra store of %h to %h",
                         $time, dataWriteData, dataAddress);
                mismatchCount++;
            end
            else if (dataAddress != expectedStoreAddress[storesSeen] ||
                     dataWriteData != expectedStoreData[storesSeen])
            begin
                $display("** Error at %0t ns: store %0d is %h at %h, expected %h at %h",
                         $time, storesSeen, dataWriteData, dataAddress,
                         expectedStoreData[storesSeen], expectedStoreAddress[storesSeen]);
                mismatchCount++;
            end
            storesSeen++;
        end
    end

    initial
    begin
        RESET = 1'b1;
        buildProgram();
        for (int i = 0; i < 256; i++)
        begin
            instrMemory[i] = cpuPkg::nopWord;
        end
        for (int i = 0; i < programWords.size(); i++)
        begin
            instrMemory[startAddress[9:2] + i] = programWords[i];
        end
        cycleLimit = programWords.size() + 20;
        repeat (2) @(posedge CLOCK);
        RESET <= 1'b0;
        @(negedge CLOCK);
        if (instrAddress != startAddress)
        begin
            $display("** Error at %0t ns: first fetch from %h, expected %h",
                     $time, instrAddress, startAddress);
            failureCount++;
        end
        while (writesSeen < expectedIndex.size() && cyclesAfterReset < cycleLimit)
        begin
            @(posedge CLOCK);
        end
        if (writesSeen < expectedIndex.size())
        begin
            $display("timeout after %0d cycles: only %0d of %0d register writes arrived",
                     cyclesAfterReset, writesSeen, expectedIndex.size());
            failureCount++;
        end
        else
        begin
            repeat (drainCycles) @(posedge CLOCK);   // stray writes after the last one
        end
        if (storesSeen != expectedStoreAddress.size())
        begin
            $display("expected %0d stores but %0d were made",
                     expectedStoreAddress.size(), storesSeen);
            failureCount++;
        end
        $display("mismatches: %0d, other failures: %0d, writes seen: %0d, stores seen: %0d",
                 mismatchCount, failureCount, writesSeen, storesSeen);
        if (mismatchCount == 0 && failureCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic            CLOCK,
    input  logic            RESET,
    input  cpuPkg::regIndex readIndexA,
    input  cpuPkg::regIndex readIndexB,
    input  logic            writeEnable,
    input  cpuPkg::regIndex writeIndex,
    input  cpuPkg::dataWord writeData,
    output cpuPkg::dataWord readDataA,
    output cpuPkg::dataWord readDataB
);

    cpuPkg::dataWord registers [32];

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 32; i++)
            begin
                registers[i] <= '0;
            end
        end
        else if (writeEnable && writeIndex != '0)
        begin
            registers[writeIndex] <= writeData;
        end
    end

    // same-cycle write goes straight through to the reader
    assign readDataA = (readIndexA == '0) ? '0 :
                       (writeEnable && writeIndex == readIndexA) ? writeData
                                                                 : registers[readIndexA];
    assign readDataB = (readIndexB == '0) ? '0 :
                       (writeEnable && writeIndex == readIndexB) ? writeData
                                                                 : registers[readIndexB];

endmodule
